// File: Makefile
# Verilator build and run for the pointer bounds check unit.

VERILATOR ?= verilator
TOP       ?= agusec_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TESTBENCH PASSED

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$($(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/agusec_properties.sv
`timescale 1ns/1ps

module agusec_properties (
  input logic                     clk,
  input logic                     rst,
  input logic                     req_valid,
  input agusec_pkg::agusec_req_t  req,
  input logic                     resp_valid,
  input agusec_pkg::agusec_resp_t resp
);

  localparam int AW = agusec_pkg::ptr_addr_w;

  logic [AW:0] req_sum;

  assign req_sum = {1'b0, req.ptr[agusec_pkg::ptr_addr_lsb +: AW]} + {1'b0, req.offset};

  // one response per request, two edges later.
  resp_latency: assert property (@(posedge clk) disable iff (rst)
    resp_valid == $past(req_valid, 2))
    else $error("resp_valid does not follow req_valid by two cycles");

  reset_quiet: assert property (@(posedge clk)
    rst |=> (!resp_valid && resp.fault == '0))
    else $error("response active right after reset");

  // overflow flag is the carry out of the 41-bit sum.
  ovf_encoding: assert property (@(posedge clk) disable iff (rst)
    resp_valid |-> resp.fault[agusec_pkg::fault_ovf_bit] == $past(req_sum[AW], 2))
    else $error("overflow bit disagrees with the request sum");

endmodule

bind agusec_unit agusec_properties props (
  .clk        (clk),
  .rst        (rst),
  .req_valid  (req_valid),
  .req        (req),
  .resp_valid (resp_valid),
  .resp       (resp)
);

// File: bench/agusec_tb.sv
`timescale 1ns/1ps

module agusec_tb;

  localparam int AW = agusec_pkg::ptr_addr_w;
  localparam int TIMEOUT_CYCLES = 20;
  localparam int RANDOM_REQS = 300;

  logic                     clk;
  logic                     rst;
  logic                     req_valid;
  agusec_pkg::agusec_req_t  req;
  logic                     resp_valid;
  agusec_pkg::agusec_resp_t resp;

  int cycle_cnt = 0;
  agusec_pkg::agusec_resp_t exp_q[$];
  int due_q[$]; // edge at which each response must be sampled.

  agusec_unit UUT (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req        (req),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic agusec_pkg::ptr_t make_ptr(input logic on_low, input agusec_pkg::bound_t hi,
      input agusec_pkg::bound_t low, input agusec_pkg::exp_t e, input agusec_pkg::addr_t addr);
    agusec_pkg::ptr_t p;
    p = '0;
    p[3:0] = 4'h9; // spare bits come back unchanged.
    p[agusec_pkg::ptr_addr_lsb +: AW] = addr;
    p[agusec_pkg::ptr_exp_lsb +: agusec_pkg::ptr_exp_w] = e;
    p[agusec_pkg::ptr_low_lsb +: agusec_pkg::ptr_low_w] = low;
    p[agusec_pkg::ptr_hi_lsb +: agusec_pkg::ptr_hi_w] = hi;
    p[agusec_pkg::ptr_on_low_bit] = on_low;
    return p;
  endfunction

  // address for exp 4 with the block above bit 12 and the window in 11..4.
  function automatic agusec_pkg::addr_t win_addr(input logic [27:0] blk,
      input agusec_pkg::window_t win, input logic [3:0] sub);
    return {blk, win, sub};
  endfunction

  function automatic agusec_pkg::agusec_resp_t agusec_model(input agusec_pkg::ptr_t p,
      input agusec_pkg::addr_t off);
    agusec_pkg::agusec_resp_t r;
    agusec_pkg::addr_t        old_a;
    agusec_pkg::addr_t        new_a;
    agusec_pkg::exp_t         e;
    agusec_pkg::bound_t       lo;
    agusec_pkg::bound_t       hi;
    agusec_pkg::window_t      win;
    agusec_pkg::window_t      low8;
    agusec_pkg::window_t      high8;
    logic [AW:0]              sum;
    logic [63:0]              u_old;
    logic [63:0]              u_new;
    logic                     on_low;
    logic                     nxt;
    logic                     diff;
    logic                     upper_bad;
    logic                     range_bad;
    int                       sh;
    old_a = p[agusec_pkg::ptr_addr_lsb +: AW];
    e = p[agusec_pkg::ptr_exp_lsb +: agusec_pkg::ptr_exp_w];
    lo = p[agusec_pkg::ptr_low_lsb +: agusec_pkg::ptr_low_w];
    hi = p[agusec_pkg::ptr_hi_lsb +: agusec_pkg::ptr_hi_w];
    on_low = p[agusec_pkg::ptr_on_low_bit];
    sum = {1'b0, old_a} + {1'b0, off};
    new_a = sum[AW-1:0];
    diff = hi < lo;
    // block rule on the bits above the window.
    sh = int'(e) + 8;
    u_old = 64'(old_a) >> sh;
    u_new = 64'(new_a) >> sh;
    nxt = on_low;
    upper_bad = 1'b0;
    if (u_new == u_old)
    begin
      nxt = on_low;
    end
    else if (diff && on_low && u_new == u_old + 64'd1)
    begin
      nxt = 1'b0;
    end
    else if (diff && !on_low && u_new == u_old - 64'd1)
    begin
      nxt = 1'b1;
    end
    else
    begin
      upper_bad = 1'b1;
    end
    // range rule uses the next on_low.
    win = 8'(new_a >> e);
    low8 = {lo, 1'b0};
    high8 = {hi, 1'b1};
    range_bad = ((win < low8) && !(diff && !nxt)) || ((win > high8) && !(diff && nxt));
    r.ptr = p;
    r.ptr[agusec_pkg::ptr_addr_lsb +: AW] = new_a;
    r.ptr[agusec_pkg::ptr_on_low_bit] = nxt;
    r.fault = '0;
    r.fault[agusec_pkg::fault_ovf_bit] = sum[AW];
    r.fault[agusec_pkg::fault_upper_bit] = upper_bad;
    r.fault[agusec_pkg::fault_range_bit] = range_bad;
    return r;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] want);
    if (got !== want)
    begin
      fail_run($sformatf("** Error at %0t: %s got %h, expected %h", $time, what, got, want));
    end
  endtask

  task automatic send_req(input agusec_pkg::ptr_t p, input agusec_pkg::addr_t off);
    req_valid = 1'b1;
    req.ptr = p;
    req.offset = off;
    exp_q.push_back(agusec_model(p, off));
    due_q.push_back(cycle_cnt + 3); // captured on the next edge and sampled two edges on.
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  // directed case with the fault class known up front.
  task automatic expect_and_send(input agusec_pkg::ptr_t p, input agusec_pkg::addr_t off,
      input agusec_pkg::fault_t want);
    agusec_pkg::agusec_resp_t m;
    m = agusec_model(p, off);
    check_value("directed fault class", 64'(m.fault), 64'(want));
    send_req(p, off);
  endtask

  task automatic idle_cycles(input int n);
    req_valid = 1'b0;
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  always @(negedge clk)
  begin : compare
    agusec_pkg::agusec_resp_t want;
    int due;
    if (!rst)
    begin
      if (resp_valid)
      begin
        if (exp_q.size() == 0)
        begin
          fail_run("response arrived with no request outstanding");
        end
        else
        begin
          want = exp_q.pop_front();
          due = due_q.pop_front();
          check_value("latency edge", 64'(cycle_cnt + 1), 64'(due));
          check_value("resp.ptr", resp.ptr, want.ptr);
          check_value("resp.fault", 64'(resp.fault), 64'(want.fault));
        end
      end
      else if (due_q.size() != 0 && due_q[0] <= cycle_cnt + 1)
      begin
        fail_run("timeout waiting for resp_valid of an outstanding request");
      end
    end
  end

  initial
  begin : main
    agusec_pkg::ptr_t  p;
    agusec_pkg::ptr_t  q;
    agusec_pkg::addr_t off;
    int n;
    void'($urandom(28));
    rst = 1'b1;
    req_valid = 1'b0;
    req = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    idle_cycles(1);

    // in-window moves within bounds 0x20..0xc1.
    p = make_ptr(1'b0, 7'h60, 7'h10, 5'd4, win_addr(28'h0000123, 8'h40, 4'h5));
    expect_and_send(p, 40'h10, 3'b000);
    expect_and_send(p, 40'h200, 3'b000);
    expect_and_send(p, 40'h80b, 3'b000); // lands exactly on high8.

    // range faults above and below.
    expect_and_send(p, 40'h820, 3'b100);
    q = make_ptr(1'b0, 7'h60, 7'h10, 5'd4, win_addr(28'h0000123, 8'h10, 4'h0));
    expect_and_send(q, 40'h0f0, 3'b100);
    expect_and_send(q, 40'h100, 3'b000);
    idle_cycles(2);

    // wrapped bounds with low8 0xc0 and high8 0x41.
    p = make_ptr(1'b1, 7'h20, 7'h60, 5'd4, win_addr(28'h0000123, 8'hf0, 4'h0));
    expect_and_send(p, 40'h200, 3'b000);
    expect_and_send(p, 40'h50, 3'b000);
    expect_and_send(p, 40'h2000, 3'b010); // two blocks up.
    q = make_ptr(1'b0, 7'h20, 7'h60, 5'd4, win_addr(28'h0000124, 8'h10, 4'h0));
    expect_and_send(q, 40'h1000, 3'b010);
    // a move down always wraps the adder, so overflow comes along.
    expect_and_send(q, 40'hff_ffff_fe00, 3'b001);
    idle_cycles(1);

    // overflow.
    p = make_ptr(1'b0, 7'h60, 7'h10, 5'd4, win_addr(28'h0000123, 8'h40, 4'h5));
    expect_and_send(p, 40'hff_ffff_ffff, 3'b001);
    p = make_ptr(1'b0, 7'h60, 7'h10, 5'd4, win_addr(28'hfff_ffff, 8'h40, 4'h0));
    expect_and_send(p, 40'h01_0000_0000, 3'b011);
    idle_cycles(2);

    // back to back random traffic.
    for (n = 0; n < RANDOM_REQS; n++)
    begin
      p = {$urandom(), $urandom()};
      off = agusec_pkg::addr_t'({$urandom(), $urandom()} >> $urandom_range(39, 0));
      send_req(p, off);
    end
    idle_cycles(1);

    n = 0;
    while (exp_q.size() != 0 && n < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0)
    begin
      fail_run("timeout waiting for the response queue to drain");
    end
    else
    begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// File: build.f
hdl/agusec_pkg.sv
hdl/get_carry.sv
hdl/agusec_shift8.sv
hdl/agusec_range.sv
hdl/agusec_check_upper.sv
hdl/agusec_unit.sv
bench/agusec_properties.sv
bench/agusec_tb.sv

// File: hdl/agusec_check_upper.sv
`timescale 1ns/1ps

// checks the address bits above the window.
// legal outcomes are the same block, or one block over when the bounds wrap.
module agusec_check_upper (
  input  agusec_pkg::ptr_t  ptr,
  input  agusec_pkg::addr_t new_addr,
  output logic              upper_ok,
  output logic              on_low_next,
  output logic              nhi_less
);

  localparam int AW = agusec_pkg::ptr_addr_w;

  agusec_pkg::exp_t   exp;
  agusec_pkg::bound_t low;
  agusec_pkg::bound_t hi;
  agusec_pkg::addr_t  old_addr;
  logic               on_low;
  logic               diff;
  logic [5:0]         base;

  agusec_pkg::addr_t msk;
  agusec_pkg::addr_t msk_lsb;
  agusec_pkg::addr_t flip;
  agusec_pkg::addr_t carry_up;
  agusec_pkg::addr_t carry_dn;
  agusec_pkg::addr_t up_bits;
  agusec_pkg::addr_t dn_bits;

  logic same;
  logic one_up;
  logic one_dn;
  logic pass_up;
  logic pass_dn;

  assign exp = ptr[agusec_pkg::ptr_exp_lsb +: agusec_pkg::ptr_exp_w];
  assign low = ptr[agusec_pkg::ptr_low_lsb +: agusec_pkg::ptr_low_w];
  assign hi = ptr[agusec_pkg::ptr_hi_lsb +: agusec_pkg::ptr_hi_w];
  assign old_addr = ptr[agusec_pkg::ptr_addr_lsb +: AW];
  assign on_low = ptr[agusec_pkg::ptr_on_low_bit];

  get_carry #(.WIDTH(7)) hi_cmp (
    .a    (hi),
    .b    (~low),
    .cin  (1'b1),
    .cout (nhi_less)   // hi >= low.
  );

  assign diff = ~nhi_less;

  // first bit above the window; at most 39.
  assign base = {1'b0, exp} + 6'd8;

  genvar i;
  generate
    for (i = 0; i < AW; i = i + 1)
    begin : g_msk
      assign msk[i] = 6'(i) >= base;
      assign msk_lsb[i] = 6'(i) == base;
    end
  endgenerate

  assign flip = old_addr ^ new_addr;

  // adding one at the block lsb flips bit i only if bit i-1 flipped
  // and carried. subtracting works the same with a borrow.
  assign carry_up = {flip[AW-2:0] & old_addr[AW-2:0], 1'b0};
  assign carry_dn = {flip[AW-2:0] & ~old_addr[AW-2:0], 1'b0};

  // bits below the block are don't care.
  assign up_bits = ~msk | ~(flip ^ (msk_lsb | carry_up));
  assign dn_bits = ~msk | ~(flip ^ (msk_lsb | carry_dn));

  assign same = ~|(flip & msk);

  // carry or borrow out of bit 39 means the block wrapped, not a legal move.
  assign one_up = &up_bits & ~(flip[AW-1] & old_addr[AW-1]);
  assign one_dn = &dn_bits & ~(flip[AW-1] & ~old_addr[AW-1]);

  assign pass_up = diff & on_low & one_up;
  assign pass_dn = diff & ~on_low & one_dn;

  assign upper_ok = same | pass_up | pass_dn;

  // a crossing always lands in the other block.
  assign on_low_next = on_low ^ (pass_up | pass_dn);

endmodule

// File: hdl/agusec_pkg.sv
package agusec_pkg;

  // pointer layout, lsb and width of each field.
  // bits 3..0 pass through untouched.
  localparam int unsigned ptr_w = 64;

  localparam int unsigned ptr_addr_lsb = 4;
  localparam int unsigned ptr_addr_w = 40;

  localparam int unsigned ptr_exp_lsb = 44;
  localparam int unsigned ptr_exp_w = 5;

  localparam int unsigned ptr_low_lsb = 49;
  localparam int unsigned ptr_low_w = 7;

  localparam int unsigned ptr_hi_lsb = 56;
  localparam int unsigned ptr_hi_w = 7;

  localparam int unsigned ptr_on_low_bit = 63;

  localparam int unsigned window_w = 8; // address bits covered by the bounds.

  // fault vector bit positions.
  localparam int unsigned fault_ovf_bit = 0;
  localparam int unsigned fault_upper_bit = 1;
  localparam int unsigned fault_range_bit = 2;

  typedef logic [ptr_w-1:0]      ptr_t;
  typedef logic [ptr_addr_w-1:0] addr_t;
  typedef logic [ptr_exp_w-1:0]  exp_t;
  typedef logic [ptr_low_w-1:0]  bound_t;
  typedef logic [window_w-1:0]   window_t;
  typedef logic [2:0]            fault_t; // all zeros means good.

  typedef struct packed {
    ptr_t  ptr;
    addr_t offset;
  } agusec_req_t;

  typedef struct packed {
    ptr_t   ptr;
    fault_t fault;
  } agusec_resp_t;

endpackage

// File: hdl/agusec_range.sv
`timescale 1ns/1ps

module agusec_range (
  input  agusec_pkg::ptr_t ptr,
  input  logic             diff,
  output logic             range_ok
);

  agusec_pkg::window_t bits;
  agusec_pkg::window_t low8;
  agusec_pkg::window_t high8;
  logic on_low;
  logic ge_low;
  logic le_high;
  logic lo_bypass;
  logic hi_bypass;

  agusec_shift8 win_sh (
    .exp  (ptr[agusec_pkg::ptr_exp_lsb +: agusec_pkg::ptr_exp_w]),
    .addr (ptr[agusec_pkg::ptr_addr_lsb +: agusec_pkg::ptr_addr_w]),
    .bits (bits)
  );

  // bounds are 7 bits, expanded to the window width.
  assign low8 = {ptr[agusec_pkg::ptr_low_lsb +: agusec_pkg::ptr_low_w], 1'b0};
  assign high8 = {ptr[agusec_pkg::ptr_hi_lsb +: agusec_pkg::ptr_hi_w], 1'b1};

  assign on_low = ptr[agusec_pkg::ptr_on_low_bit];

  get_carry #(.WIDTH(8)) low_cmp (
    .a    (bits),
    .b    (~low8),
    .cin  (1'b1),
    .cout (ge_low)     // bits >= low8.
  );

  get_carry #(.WIDTH(8)) high_cmp (
    .a    (high8),
    .b    (~bits),
    .cin  (1'b1),
    .cout (le_high)    // bits <= high8.
  );

  // wrapped bounds, only one side applies in each block.
  assign lo_bypass = diff & ~on_low;
  assign hi_bypass = diff & on_low;

  assign range_ok = (ge_low | lo_bypass) & (le_high | hi_bypass);

endmodule

// File: hdl/agusec_shift8.sv
`timescale 1ns/1ps

module agusec_shift8 (
  input  agusec_pkg::exp_t    exp,
  input  agusec_pkg::addr_t   addr,
  output agusec_pkg::window_t bits
);

  agusec_pkg::addr_t sh1;
  agusec_pkg::addr_t sh2;
  agusec_pkg::addr_t sh4;
  agusec_pkg::addr_t sh8;
  agusec_pkg::addr_t sh16;

  // one level per exponent bit, smallest step first.
  assign sh1 = exp[0] ? (addr >> 1) : addr;
  assign sh2 = exp[1] ? (sh1 >> 2) : sh1;
  assign sh4 = exp[2] ? (sh2 >> 4) : sh2;
  assign sh8 = exp[3] ? (sh4 >> 8) : sh4;
  assign sh16 = exp[4] ? (sh8 >> 16) : sh8;

  // exp tops out at 31, so bit 38 is the highest one ever reached.
  assign bits = sh16[agusec_pkg::window_w-1:0];

endmodule

// File: hdl/agusec_unit.sv
`timescale 1ns/1ps

module agusec_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req_valid,
  input  agusec_pkg::agusec_req_t  req,
  output logic                     resp_valid,
  output agusec_pkg::agusec_resp_t resp
);

  localparam int AW = agusec_pkg::ptr_addr_w;

  agusec_pkg::addr_t  req_addr;
  logic [AW:0]        sum;

  logic               s1_valid;
  agusec_pkg::ptr_t   s1_ptr;
  logic [AW:0]        s1_sum;     // top bit is the overflow.

  agusec_pkg::addr_t  new_addr;
  agusec_pkg::ptr_t   new_ptr;
  agusec_pkg::fault_t fault;
  logic               upper_ok;
  logic               on_low_next;
  logic               nhi_less;
  logic               range_ok;

  // stage 1, the add.
  assign req_addr = req.ptr[agusec_pkg::ptr_addr_lsb +: AW];
  assign sum = {1'b0, req_addr} + {1'b0, req.offset};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      s1_valid <= 1'b0;
    end
    else
    begin
      s1_valid <= req_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (req_valid)
    begin
      s1_ptr <= req.ptr;
      s1_sum <= sum;
    end
  end

  // stage 2, the checks.
  assign new_addr = s1_sum[AW-1:0];

  agusec_check_upper upper_chk (
    .ptr         (s1_ptr),
    .new_addr    (new_addr),
    .upper_ok    (upper_ok),
    .on_low_next (on_low_next),
    .nhi_less    (nhi_less)
  );

  always_comb
  begin
    new_ptr = s1_ptr;
    new_ptr[agusec_pkg::ptr_addr_lsb +: AW] = new_addr;
    new_ptr[agusec_pkg::ptr_on_low_bit] = on_low_next;
  end

  // range check sees the candidate pointer in its new block.
  agusec_range range_chk (
    .ptr      (new_ptr),
    .diff     (~nhi_less),
    .range_ok (range_ok)
  );

  always_comb
  begin
    fault = '0;
    fault[agusec_pkg::fault_ovf_bit] = s1_sum[AW];
    fault[agusec_pkg::fault_upper_bit] = ~upper_ok;
    fault[agusec_pkg::fault_range_bit] = ~range_ok;
  end

  // response register; pointer goes out even when faulted.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      resp_valid <= 1'b0;
      resp.fault <= '0;
    end
    else
    begin
      resp_valid <= s1_valid;
      if (s1_valid)
      begin
        resp.ptr <= new_ptr;
        resp.fault <= fault;
      end
    end
  end

endmodule

// File: hdl/get_carry.sv
`timescale 1ns/1ps

// carry out of a + b + cin.
// with b inverted and cin set this gives a >= b.
module get_carry #(
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic             cin,
  output logic             cout
);

  // slot 0 holds the carry in, slots 1..WIDTH the operand bits.
  localparam int N = WIDTH + 1;
  localparam int LEVELS = $clog2(N);

  logic [N-1:0] g [0:LEVELS];
  logic [N-1:0] p [0:LEVELS];

  assign g[0] = {a & b, cin};
  assign p[0] = {a ^ b, 1'b0}; // cin slot never propagates.

  // kogge-stone style prefix levels.
  // span doubles per level; bits shifted in as zero are already final.
  genvar lv;
  generate
    for (lv = 0; lv < LEVELS; lv = lv + 1)
    begin : g_level
      localparam int D = 1 << lv;

      assign g[lv+1] = g[lv] | (p[lv] & (g[lv] << D));
      assign p[lv+1] = p[lv] & (p[lv] << D);
    end
  endgenerate

  assign cout = g[LEVELS][N-1]; // group generate over all slots.

endmodule
